// ==== design/pc_types_pkg.sv ====
package pc_types_pkg;

    // ##############################
    // Datapath widths
    // ##############################

    // Byte address of an instruction, always word aligned in this core
    typedef logic [31:0] addr_t;

    // Immediate after sign extension by the decoder
    typedef logic [31:0] imm_t;

    // Value read from the register file for rs1 or rs2
    typedef logic [31:0] operand_t;

    // Branch condition field of a B-type instruction
    typedef logic [2:0] funct3_t;

endpackage

// ==== design/ctrl_types_pkg.sv ====
package ctrl_types_pkg;

    // Control-flow class of a decoded instruction
    typedef enum logic [1:0] {
        kind_none   = 2'd0,
        kind_branch = 2'd1,
        kind_jal    = 2'd2,
        kind_jalr   = 2'd3
    } ctrl_kind_t;

    // ##############################
    // Conditional branch funct3 codes
    // ##############################

    localparam logic [2:0] funct3_beq  = 3'b000;
    localparam logic [2:0] funct3_bne  = 3'b001;
    localparam logic [2:0] funct3_blt  = 3'b100;
    localparam logic [2:0] funct3_bge  = 3'b101;
    localparam logic [2:0] funct3_bltu = 3'b110;
    localparam logic [2:0] funct3_bgeu = 3'b111;

endpackage

// ==== design/branch_resolver.sv ====
`timescale 1ns/1ps

module branch_resolver
    import pc_types_pkg::*;
    import ctrl_types_pkg::*;
(
    input  ctrl_kind_t id_ex_kind,
    input  addr_t      id_ex_pc,
    input  imm_t       id_ex_imm,
    input  operand_t   id_ex_rs1,
    input  operand_t   id_ex_rs2,
    input  funct3_t    id_ex_funct3,
    output logic       resolved_taken,
    output addr_t      resolved_target
);

    addr_t pc_plus_imm;
    addr_t rs1_plus_imm;
    addr_t jalr_target;

    logic rs_equal;
    logic rs_less_signed;
    logic rs_less_unsigned;
    logic branch_cond;

    // ##############################
    // Target arithmetic
    // ##############################

    assign pc_plus_imm  = id_ex_pc + id_ex_imm;
    assign rs1_plus_imm = id_ex_rs1 + id_ex_imm;

    // jalr clears bit 0 of the sum
    assign jalr_target = {rs1_plus_imm[$bits(addr_t)-1:1], 1'b0};

    // ##############################
    // Branch compare
    // ##############################

    assign rs_equal         = (id_ex_rs1 == id_ex_rs2);
    assign rs_less_signed   = ($signed(id_ex_rs1) < $signed(id_ex_rs2));
    assign rs_less_unsigned = (id_ex_rs1 < id_ex_rs2);

    always_comb begin
        case (id_ex_funct3)
            funct3_beq:  branch_cond = rs_equal;
            funct3_bne:  branch_cond = !rs_equal;
            funct3_blt:  branch_cond = rs_less_signed;
            funct3_bge:  branch_cond = !rs_less_signed;
            funct3_bltu: branch_cond = rs_less_unsigned;
            funct3_bgeu: branch_cond = !rs_less_unsigned;
            // Codes 010 and 011 are not branches
            default:     branch_cond = 1'b0;
        endcase
    end

    // ##############################
    // Outcome
    // ##############################

    always_comb begin
        case (id_ex_kind)
            kind_branch: begin
                resolved_taken  = branch_cond;
                resolved_target = pc_plus_imm;
            end
            kind_jal: begin
                resolved_taken  = 1'b1;
                resolved_target = pc_plus_imm;
            end
            kind_jalr: begin
                resolved_taken  = 1'b1;
                resolved_target = jalr_target;
            end
            default: begin
                resolved_taken  = 1'b0;
                resolved_target = pc_plus_imm;
            end
        endcase
    end

endmodule

// ==== design/btb_predictor.sv ====
`timescale 1ns/1ps

module btb_predictor
    import pc_types_pkg::*;
    import ctrl_types_pkg::*;
#(
    parameter int BTB_ENTRIES = 32
) (
    input  logic       clk,
    input  logic       reset,
    input  addr_t      current_pc,
    input  addr_t      if_id_pc,
    input  logic       if_id_valid,
    input  logic       id_ex_valid,
    input  addr_t      id_ex_pc,
    input  ctrl_kind_t id_ex_kind,
    input  logic       resolved_taken,
    input  addr_t      resolved_target,
    output addr_t      predicted_pc,
    output logic       flush,
    output addr_t      redirect_pc
);

    localparam int INDEX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W   = $bits(addr_t) - INDEX_W - 2;

    typedef logic [INDEX_W-1:0] btb_index_t;
    typedef logic [TAG_W-1:0]   btb_tag_t;

    // ##############################
    // Table storage
    // ##############################

    logic [BTB_ENTRIES-1:0] valid_table;
    btb_tag_t               tag_table [BTB_ENTRIES];
    addr_t                  target_table [BTB_ENTRIES];

    btb_index_t lookup_index;
    btb_tag_t   lookup_tag;
    logic       lookup_hit;

    btb_index_t update_index;
    btb_tag_t   update_tag;

    logic  is_ctrl;
    addr_t resolved_next_pc;

    // ##############################
    // Lookup on the fetch PC
    // ##############################

    // Bits 1:0 are always zero, so the index starts at bit 2
    assign lookup_index = current_pc[INDEX_W+1:2];
    assign lookup_tag   = current_pc[$bits(addr_t)-1:INDEX_W+2];

    assign lookup_hit = valid_table[lookup_index]
                        && (tag_table[lookup_index] == lookup_tag);

    // Every stored entry is a taken prediction
    assign predicted_pc = lookup_hit ? target_table[lookup_index]
                                     : current_pc + 32'd4;

    // ##############################
    // Mispredict detection
    // ##############################

    assign is_ctrl = id_ex_valid && (id_ex_kind != kind_none);

    assign resolved_next_pc = resolved_taken ? resolved_target
                                             : id_ex_pc + 32'd4;

    // An empty IF/ID means nothing was fetched down either path, which is
    // just as wrong as a fetch down the wrong one
    assign flush = is_ctrl
                   && (!if_id_valid || (if_id_pc != resolved_next_pc));

    assign redirect_pc = resolved_next_pc;

    // ##############################
    // Table update
    // ##############################

    assign update_index = id_ex_pc[INDEX_W+1:2];
    assign update_tag   = id_ex_pc[$bits(addr_t)-1:INDEX_W+2];

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_table <= '0;
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                tag_table[i]    <= '0;
                target_table[i] <= '0;
            end
        end else if (flush) begin
            // A not-taken branch drops its entry so the next visit falls through
            valid_table[update_index]  <= resolved_taken;
            tag_table[update_index]    <= update_tag;
            target_table[update_index] <= resolved_target;
        end
    end

    // ##############################
    // Checks
    // ##############################

    flush_needs_id_ex: assert property (
        @(posedge clk) disable iff (reset)
        flush |-> id_ex_valid
    );

endmodule

// ==== design/fetch_pipeline.sv ====
`timescale 1ns/1ps

module fetch_pipeline
    import pc_types_pkg::*;
    import ctrl_types_pkg::*;
#(
    parameter addr_t RESET_PC = '0
) (
    input  logic       clk,
    input  logic       reset,

    output logic       fetch_valid,
    output addr_t      fetch_pc,
    input  logic       fetch_ready,

    output logic       decode_valid,
    input  logic       decode_ready,
    input  ctrl_kind_t decode_kind,
    input  imm_t       decode_imm,
    input  operand_t   decode_rs1,
    input  operand_t   decode_rs2,
    input  funct3_t    decode_funct3,

    input  addr_t      predicted_pc,
    input  logic       flush,
    input  addr_t      redirect_pc,

    output addr_t      if_id_pc,
    output logic       if_id_valid,
    output addr_t      id_ex_pc,
    output logic       id_ex_valid,
    output ctrl_kind_t id_ex_kind,
    output imm_t       id_ex_imm,
    output operand_t   id_ex_rs1,
    output operand_t   id_ex_rs2,
    output funct3_t    id_ex_funct3
);

    logic if_id_stalled;
    logic fetch_fire;
    logic decode_fire;

    // ##############################
    // Handshakes
    // ##############################

    assign if_id_stalled = if_id_valid && !decode_ready;

    // Fetch can only be taken when IF/ID has room this cycle
    assign fetch_valid = !if_id_stalled;
    assign fetch_fire  = fetch_valid && fetch_ready;

    // The instruction behind a mispredict is wrong path and is not offered
    assign decode_valid = if_id_valid && !flush;
    assign decode_fire  = decode_valid && decode_ready;

    // ##############################
    // Fetch PC
    // ##############################

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= RESET_PC;
        end else if (flush) begin
            fetch_pc <= redirect_pc;
        end else if (fetch_fire) begin
            fetch_pc <= predicted_pc;
        end
    end

    // ##############################
    // IF/ID and ID/EX
    // ##############################

    always_ff @(posedge clk) begin
        if (reset) begin
            if_id_valid <= 1'b0;
        end else if (flush) begin
            if_id_valid <= 1'b0;
        end else if (fetch_fire) begin
            if_id_valid <= 1'b1;
        end else if (decode_fire) begin
            if_id_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire && !flush) begin
            if_id_pc <= fetch_pc;
        end
    end

    // EX never stalls, so ID/EX is valid for a single cycle per instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            id_ex_valid <= 1'b0;
        end else begin
            id_ex_valid <= decode_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_fire) begin
            id_ex_pc     <= if_id_pc;
            id_ex_kind   <= decode_kind;
            id_ex_imm    <= decode_imm;
            id_ex_rs1    <= decode_rs1;
            id_ex_rs2    <= decode_rs2;
            id_ex_funct3 <= decode_funct3;
        end
    end

    // A stalled IF/ID keeps its instruction until decode takes it or a flush
    if_id_holds_on_stall: assert property (
        @(posedge clk) disable iff (reset)
        (if_id_stalled && !flush) |=> (if_id_valid && $stable(if_id_pc))
    );

endmodule

// ==== design/fetch_redirect_top.sv ====
`timescale 1ns/1ps

module fetch_redirect_top
    import pc_types_pkg::*;
    import ctrl_types_pkg::*;
#(
    parameter int    BTB_ENTRIES = 32,
    parameter addr_t RESET_PC    = '0
) (
    input  logic       clk,
    input  logic       reset,

    output logic       fetch_valid,
    output addr_t      fetch_pc,
    input  logic       fetch_ready,

    output logic       decode_valid,
    output addr_t      decode_pc,
    input  logic       decode_ready,
    input  ctrl_kind_t decode_kind,
    input  imm_t       decode_imm,
    input  operand_t   decode_rs1,
    input  operand_t   decode_rs2,
    input  funct3_t    decode_funct3,

    output logic       redirect_valid,
    output addr_t      redirect_pc
);

    addr_t      predicted_pc;
    logic       if_id_valid;
    addr_t      id_ex_pc;
    logic       id_ex_valid;
    ctrl_kind_t id_ex_kind;
    imm_t       id_ex_imm;
    operand_t   id_ex_rs1;
    operand_t   id_ex_rs2;
    funct3_t    id_ex_funct3;
    logic       resolved_taken;
    addr_t      resolved_target;

    // The IF/ID PC is what decode sees, and the flush is the redirect
    fetch_pipeline #(
        .RESET_PC (RESET_PC)
    ) u_fetch_pipeline (
        .clk           (clk),
        .reset         (reset),
        .fetch_valid   (fetch_valid),
        .fetch_pc      (fetch_pc),
        .fetch_ready   (fetch_ready),
        .decode_valid  (decode_valid),
        .decode_ready  (decode_ready),
        .decode_kind   (decode_kind),
        .decode_imm    (decode_imm),
        .decode_rs1    (decode_rs1),
        .decode_rs2    (decode_rs2),
        .decode_funct3 (decode_funct3),
        .predicted_pc  (predicted_pc),
        .flush         (redirect_valid),
        .redirect_pc   (redirect_pc),
        .if_id_pc      (decode_pc),
        .if_id_valid   (if_id_valid),
        .id_ex_pc      (id_ex_pc),
        .id_ex_valid   (id_ex_valid),
        .id_ex_kind    (id_ex_kind),
        .id_ex_imm     (id_ex_imm),
        .id_ex_rs1     (id_ex_rs1),
        .id_ex_rs2     (id_ex_rs2),
        .id_ex_funct3  (id_ex_funct3)
    );

    branch_resolver u_branch_resolver (
        .id_ex_kind      (id_ex_kind),
        .id_ex_pc        (id_ex_pc),
        .id_ex_imm       (id_ex_imm),
        .id_ex_rs1       (id_ex_rs1),
        .id_ex_rs2       (id_ex_rs2),
        .id_ex_funct3    (id_ex_funct3),
        .resolved_taken  (resolved_taken),
        .resolved_target (resolved_target)
    );

    btb_predictor #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_btb_predictor (
        .clk             (clk),
        .reset           (reset),
        .current_pc      (fetch_pc),
        .if_id_pc        (decode_pc),
        .if_id_valid     (if_id_valid),
        .id_ex_valid     (id_ex_valid),
        .id_ex_pc        (id_ex_pc),
        .id_ex_kind      (id_ex_kind),
        .resolved_taken  (resolved_taken),
        .resolved_target (resolved_target),
        .predicted_pc    (predicted_pc),
        .flush           (redirect_valid),
        .redirect_pc     (redirect_pc)
    );

endmodule

// ==== tests/fetch_redirect_tb.sv ====
`timescale 1ns/1ps

module fetch_redirect_tb
    import pc_types_pkg::*;
    import ctrl_types_pkg::*;
();

    localparam int    BTB_ENTRIES = 32;
    localparam addr_t RESET_PC    = 32'h0000_0000;
    localparam int    INDEX_W     = $clog2(BTB_ENTRIES);

    localparam int TRANSFER_TARGET = 240;
    localparam int RUN_TIMEOUT     = 4000;

    // ##############################
    // Program
    // ##############################

    // A jal skips ahead into a four instruction loop, and jalr returns near the start
    localparam addr_t    JAL_PC      = 32'h0000_0008;
    localparam addr_t    JAL_TARGET  = 32'h0000_0020;
    localparam addr_t    LOOP_PC     = 32'h0000_002c;
    localparam addr_t    LOOP_TARGET = 32'h0000_0020;
    localparam addr_t    JALR_PC     = 32'h0000_0030;
    localparam operand_t JALR_BASE   = 32'h0000_0015;
    localparam imm_t     JALR_OFFSET = 32'hffff_fff0;

    localparam operand_t ONE       = 32'd1;
    localparam operand_t MINUS_ONE = 32'hffff_ffff;

    logic       clk;
    logic       reset;
    logic       fetch_valid;
    addr_t      fetch_pc;
    logic       fetch_ready;
    logic       decode_valid;
    addr_t      decode_pc;
    logic       decode_ready;
    ctrl_kind_t decode_kind;
    imm_t       decode_imm;
    operand_t   decode_rs1;
    operand_t   decode_rs2;
    funct3_t    decode_funct3;
    logic       redirect_valid;
    addr_t      redirect_pc;

    int    loop_visits;
    int    transfers;
    int    redirects;
    logic  decode_fire;
    logic  if_id_full;
    logic  ex_valid;
    logic  ex_ctrl;
    logic  ex_taken;
    addr_t ex_pc;
    addr_t ex_next_pc;

    logic [BTB_ENTRIES-1:0] shadow_valid;
    addr_t                  shadow_pc [BTB_ENTRIES];
    addr_t                  shadow_target [BTB_ENTRIES];
    logic [INDEX_W-1:0]     fetch_index;
    logic [INDEX_W-1:0]     ex_index;
    addr_t                  expected_next_fetch;
    logic                   expected_flush;

    fetch_redirect_top #(
        .BTB_ENTRIES (BTB_ENTRIES),
        .RESET_PC    (RESET_PC)
    ) UUT (
        .clk            (clk),
        .reset          (reset),
        .fetch_valid    (fetch_valid),
        .fetch_pc       (fetch_pc),
        .fetch_ready    (fetch_ready),
        .decode_valid   (decode_valid),
        .decode_pc      (decode_pc),
        .decode_ready   (decode_ready),
        .decode_kind    (decode_kind),
        .decode_imm     (decode_imm),
        .decode_rs1     (decode_rs1),
        .decode_rs2     (decode_rs2),
        .decode_funct3  (decode_funct3),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // The loop branch falls through on every fourth visit
    function automatic logic loop_taken(input int visit);
        return (visit % 4) != 3;
    endfunction

    function automatic logic is_control(input addr_t pc);
        return (pc == JAL_PC) || (pc == LOOP_PC) || (pc == JALR_PC);
    endfunction

    function automatic logic program_taken(input addr_t pc, input int visit);
        if (pc == LOOP_PC) begin
            return loop_taken(visit);
        end
        return (pc == JAL_PC) || (pc == JALR_PC);
    endfunction

    function automatic addr_t program_next_pc(input addr_t pc, input int visit);
        if (pc == JAL_PC) begin
            return JAL_TARGET;
        end
        if (pc == JALR_PC) begin
            return (JALR_BASE + JALR_OFFSET) & ~32'd1;
        end
        if (pc == LOOP_PC && loop_taken(visit)) begin
            return LOOP_TARGET;
        end
        return pc + 32'd4;
    endfunction

    // Each visit of the loop branch uses the next compare in turn
    function automatic funct3_t branch_code(input int visit);
        case (visit % 6)
            0:       return funct3_beq;
            1:       return funct3_bne;
            2:       return funct3_blt;
            3:       return funct3_bge;
            4:       return funct3_bltu;
            default: return funct3_bgeu;
        endcase
    endfunction

    task automatic drive_cycle_inputs();
        logic taken;
        taken         = loop_taken(loop_visits);
        fetch_ready   = ($urandom % 4) != 0;
        decode_ready  = ($urandom % 4) != 0;
        decode_kind   = kind_none;
        decode_imm    = $urandom;
        decode_rs1    = $urandom;
        decode_rs2    = $urandom;
        decode_funct3 = funct3_t'($urandom_range(7, 0));
        if (decode_pc == JAL_PC) begin
            decode_kind = kind_jal;
            decode_imm  = JAL_TARGET - JAL_PC;
        end else if (decode_pc == JALR_PC) begin
            decode_kind = kind_jalr;
            decode_imm  = JALR_OFFSET;
            decode_rs1  = JALR_BASE;
        end else if (decode_pc == LOOP_PC) begin
            decode_kind   = kind_branch;
            decode_imm    = LOOP_TARGET - LOOP_PC;
            decode_funct3 = branch_code(loop_visits);
            // Operand pairs where signed and unsigned order disagree
            case (decode_funct3)
                funct3_beq:  {decode_rs1, decode_rs2} = taken ? {ONE, ONE} : {ONE, MINUS_ONE};
                funct3_bne:  {decode_rs1, decode_rs2} = taken ? {ONE, MINUS_ONE} : {ONE, ONE};
                funct3_blt:  {decode_rs1, decode_rs2} = taken ? {MINUS_ONE, ONE} : {ONE, MINUS_ONE};
                funct3_bge:  {decode_rs1, decode_rs2} = taken ? {ONE, MINUS_ONE} : {MINUS_ONE, ONE};
                funct3_bltu: {decode_rs1, decode_rs2} = taken ? {ONE, MINUS_ONE} : {MINUS_ONE, ONE};
                default:     {decode_rs1, decode_rs2} = taken ? {MINUS_ONE, ONE} : {ONE, MINUS_ONE};
            endcase
        end
    endtask

    // ##############################
    // Reference model
    // ##############################

    assign decode_fire = decode_valid && decode_ready;

    always @(posedge clk) begin
        if (reset) begin
            if_id_full  <= 1'b0;
            ex_valid    <= 1'b0;
            loop_visits <= 0;
            transfers   <= 0;
            redirects   <= 0;
        end else begin
            if (redirect_valid) begin
                if_id_full <= 1'b0;
                redirects  <= redirects + 1;
            end else if (fetch_valid && fetch_ready) begin
                if_id_full <= 1'b1;
            end else if (decode_fire) begin
                if_id_full <= 1'b0;
            end
            ex_valid <= decode_fire;
            if (decode_fire) begin
                transfers <= transfers + 1;
                if (decode_pc == LOOP_PC) begin
                    loop_visits <= loop_visits + 1;
                end
            end
        end
        ex_pc      <= decode_pc;
        ex_ctrl    <= is_control(decode_pc);
        ex_taken   <= program_taken(decode_pc, loop_visits);
        ex_next_pc <= program_next_pc(decode_pc, loop_visits);
    end

    assign ex_index    = ex_pc[INDEX_W+1:2];
    assign fetch_index = fetch_pc[INDEX_W+1:2];

    always @(posedge clk) begin
        if (reset) begin
            shadow_valid <= '0;
        end else if (redirect_valid) begin
            shadow_valid[ex_index]  <= ex_taken;
            shadow_pc[ex_index]     <= ex_pc;
            shadow_target[ex_index] <= ex_next_pc;
        end
    end

    always_comb begin
        if (shadow_valid[fetch_index] && shadow_pc[fetch_index] == fetch_pc) begin
            expected_next_fetch = shadow_target[fetch_index];
        end else begin
            expected_next_fetch = fetch_pc + 32'd4;
        end
    end

    assign expected_flush = ex_valid && ex_ctrl && (!if_id_full || decode_pc != ex_next_pc);

    // ##############################
    // Checks
    // ##############################

    reset_state: assert property (@(posedge clk)
        $fell(reset) |-> (fetch_valid && fetch_pc == RESET_PC && !decode_valid && !redirect_valid))
        else stop_on_error($sformatf("CHECK FAILED at %0t: outputs wrong after reset", $time));

    fetch_hold: assert property (@(posedge clk) disable iff (reset)
        (!fetch_ready && !redirect_valid) |=> $stable(fetch_pc))
        else stop_on_error($sformatf("CHECK FAILED at %0t: fetch_pc moved while stalled", $time));

    decode_hold: assert property (@(posedge clk) disable iff (reset)
        (decode_valid && !decode_ready && !redirect_valid) |=> $stable(decode_pc))
        else stop_on_error($sformatf("CHECK FAILED at %0t: decode_pc moved while stalled", $time));

    redirect_target: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |-> (ex_valid && ex_ctrl && redirect_pc == ex_next_pc))
        else stop_on_error($sformatf("CHECK FAILED at %0t: redirect_pc %h, expected %h",
                                     $time, redirect_pc, ex_next_pc));

    redirect_effect: assert property (@(posedge clk) disable iff (reset)
        redirect_valid |=> (fetch_pc == $past(redirect_pc) && !decode_valid))
        else stop_on_error($sformatf("CHECK FAILED at %0t: fetch not redirected", $time));

    next_fetch: assert property (@(posedge clk) disable iff (reset)
        (fetch_valid && fetch_ready && !redirect_valid)
        |=> (fetch_pc == $past(expected_next_fetch)))
        else stop_on_error($sformatf("CHECK FAILED at %0t: fetch_pc %h does not follow the BTB",
                                     $time, fetch_pc));

    flush_exact: assert property (@(posedge clk) disable iff (reset)
        redirect_valid == expected_flush)
        else stop_on_error($sformatf("CHECK FAILED at %0t: redirect_valid %b, expected %b",
                                     $time, redirect_valid, expected_flush));

    // ##############################
    // Stimulus
    // ##############################

    initial begin : stimulus
        int cycles;
        void'($urandom(53221));
        reset         = 1'b1;
        fetch_ready   = 1'b0;
        decode_ready  = 1'b0;
        decode_kind   = kind_none;
        decode_imm    = '0;
        decode_rs1    = '0;
        decode_rs2    = '0;
        decode_funct3 = '0;
        repeat (10) @(posedge clk);
        #1;
        reset  = 1'b0;
        cycles = 0;
        while (transfers < TRANSFER_TARGET && cycles < RUN_TIMEOUT) begin
            drive_cycle_inputs();
            @(posedge clk);
            #1;
            cycles++;
        end
        if (transfers < TRANSFER_TARGET) begin
            stop_on_error($sformatf("Timed out after %0d cycles with only %0d decode transfers",
                                    cycles, transfers));
        end else if (redirects == 0) begin
            stop_on_error("The run finished without a single redirect");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
design/pc_types_pkg.sv
design/ctrl_types_pkg.sv
design/branch_resolver.sv
design/btb_predictor.sv
design/fetch_pipeline.sv
design/fetch_redirect_top.sv
tests/fetch_redirect_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module fetch_redirect_tb -f filelist.f \
    > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vfetch_redirect_tb > sim.log 2>&1
cat sim.log
grep -qx "TEST OK" sim.log && exit 0 || exit 1
